// ==== rtl/net_tx_params.svh ====
`ifndef NET_TX_PARAMS_SVH
`define NET_TX_PARAMS_SVH

// ----------------------------------------
// payload and buffering
// ----------------------------------------
`define NET_MAX_PAYLOAD   1472   // largest udp payload, fits one frame
`define NET_FIFO_DEPTH    2048   // payload buffer bytes, power of two
`define NET_DESC_DEPTH    4      // packets queued, power of two

// ----------------------------------------
// header values
// ----------------------------------------
`define NET_LOCAL_PORT    16'd1024   // udp source port
`define NET_IP_TTL        8'd128

// ----------------------------------------
// frame timing
// ----------------------------------------
`define NET_PREAMBLE_LEN  7      // 55h bytes before sfd
`define NET_MIN_DATA      46     // ethernet data minimum, padded up to this
`define NET_IFG_CYCLES    12     // idle cycles between frames

`endif

// ==== rtl/net_frame_pkg.sv ====
`default_nettype none

// wire-format types, shared by every stage of the transmit path
package net_frame_pkg;

  typedef logic [7:0]  byte_t;      // one octet on the phy
  typedef logic [47:0] mac_addr_t;
  typedef logic [31:0] ip_addr_t;
  typedef logic [15:0] udp_port_t;
  typedef logic [15:0] len_t;       // byte counts
  typedef logic [15:0] csum_t;      // ones-complement sum
  typedef logic [31:0] crc_t;       // fcs, reflected form
  typedef logic [15:0] ip_id_t;     // ipv4 identification

  // ----------------------------------------
  // destination of one packet
  // ----------------------------------------
  typedef struct packed {
    mac_addr_t mac;
    ip_addr_t  ip;
    udp_port_t port;
  } dest_t;                         // 96 bits

endpackage

`default_nettype wire

// ==== rtl/net_ctrl_pkg.sv ====
`default_nettype none

// internal handshake payloads and state encodings
package net_ctrl_pkg;

  import net_frame_pkg::*;

  // one byte of the ip/udp stream into the framer
  typedef struct packed {
    byte_t data;
    logic  last;      // final payload byte
  } beat_t;

  // queued packet, pushed once its payload is fully buffered
  typedef struct packed {
    len_t  len;       // payload bytes
    dest_t dest;      // held destination at the last byte
  } desc_t;

  // ----------------------------------------
  // fsm encodings
  // ----------------------------------------
  typedef enum logic [2:0] {
    FR_IDLE,
    FR_PREAMBLE,
    FR_SFD,
    FR_MAC_HDR,
    FR_DATA,
    FR_PAD,
    FR_FCS,
    FR_GAP
  } frame_state_t;

  typedef enum logic [1:0] {
    HG_IDLE,
    HG_SUM,         // header checksum, one word per cycle
    HG_HEADER,
    HG_PAYLOAD
  } hdr_state_t;

endpackage

`default_nettype wire

// ==== rtl/udp_tx_intake.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "net_tx_params.svh"

module udp_tx_intake
  import net_frame_pkg::*;
  import net_ctrl_pkg::*;
(
  input  wire       tx_clock,
  input  wire       rst_n,
  input  wire byte_t     udp_tx_data,
  input  wire            udp_tx_valid,
  output logic           udp_tx_ready,
  input  wire len_t      udp_tx_length,
  input  wire            run,
  input  wire mac_addr_t dest_mac,
  input  wire ip_addr_t  dest_ip,
  input  wire udp_port_t dest_port,
  output desc_t          desc,
  output logic           desc_valid,
  input  wire            desc_ready,
  output byte_t          pay_data,
  input  wire            pay_pop
);

  localparam int unsigned BUF_AW  = $clog2(`NET_FIFO_DEPTH);
  localparam int unsigned DESC_AW = $clog2(`NET_DESC_DEPTH);

  byte_t            buf_mem [`NET_FIFO_DEPTH];
  logic [BUF_AW:0]  buf_wr_ptr;    // extra msb tells full from empty
  logic [BUF_AW:0]  buf_rd_ptr;
  logic [BUF_AW:0]  buf_fill;

  desc_t            desc_mem [`NET_DESC_DEPTH];
  logic [DESC_AW:0] desc_wr_ptr;
  logic [DESC_AW:0] desc_rd_ptr;
  logic [DESC_AW:0] desc_fill;

  dest_t held_dest;    // frozen while run is high
  len_t  pkt_len;      // length sampled with first byte
  len_t  bytes_left;   // countdown inside a packet
  logic  in_pkt;
  len_t  cur_len;
  len_t  cur_left;
  logic  byte_xfer;
  logic  last_byte;

  // ----------------------------------------
  // occupancy and handshake
  // ----------------------------------------
  assign buf_fill     = buf_wr_ptr - buf_rd_ptr;
  assign desc_fill    = desc_wr_ptr - desc_rd_ptr;
  // msb of fill set only at exactly full
  assign udp_tx_ready = !buf_fill[BUF_AW] && !desc_fill[DESC_AW];
  assign byte_xfer    = udp_tx_valid && udp_tx_ready;

  // first byte of a packet takes the length from the port
  assign cur_len   = in_pkt ? pkt_len : udp_tx_length;
  assign cur_left  = in_pkt ? bytes_left : udp_tx_length;
  assign last_byte = cur_left == len_t'(1);

  assign pay_data   = buf_mem[buf_rd_ptr[BUF_AW-1:0]];   // oldest byte, no latency
  assign desc_valid = desc_wr_ptr != desc_rd_ptr;
  assign desc       = desc_mem[desc_rd_ptr[DESC_AW-1:0]];

  // ----------------------------------------
  // storage
  // ----------------------------------------
  always_ff @(posedge tx_clock) begin
    if (!run) begin
      held_dest <= '{mac: dest_mac, ip: dest_ip, port: dest_port};
    end
    if (byte_xfer) begin
      buf_mem[buf_wr_ptr[BUF_AW-1:0]] <= udp_tx_data;
      if (!in_pkt) begin
        pkt_len <= udp_tx_length;
      end
      if (last_byte) begin   // payload complete, queue it
        desc_mem[desc_wr_ptr[DESC_AW-1:0]] <= '{len: cur_len, dest: held_dest};
      end
    end
  end

  // ----------------------------------------
  // pointers and packet tracking
  // ----------------------------------------
  always_ff @(posedge tx_clock) begin
    if (!rst_n) begin
      buf_wr_ptr  <= '0;
      buf_rd_ptr  <= '0;
      desc_wr_ptr <= '0;
      desc_rd_ptr <= '0;
      bytes_left  <= '0;
      in_pkt      <= 1'b0;
    end else begin
      if (byte_xfer) begin
        buf_wr_ptr <= buf_wr_ptr + 1'b1;
        if (last_byte) begin
          in_pkt      <= 1'b0;
          desc_wr_ptr <= desc_wr_ptr + 1'b1;
        end else begin
          in_pkt     <= 1'b1;
          bytes_left <= cur_left - len_t'(1);
        end
      end
      if (pay_pop) begin
        buf_rd_ptr <= buf_rd_ptr + 1'b1;
      end
      if (desc_valid && desc_ready) begin
        desc_rd_ptr <= desc_rd_ptr + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// ==== rtl/ip_udp_header_gen.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "net_tx_params.svh"

module ip_udp_header_gen
  import net_frame_pkg::*;
  import net_ctrl_pkg::*;
(
  input  wire            tx_clock,
  input  wire            rst_n,
  input  wire ip_addr_t  local_ip,
  input  wire desc_t     desc,
  input  wire            desc_valid,
  output logic           desc_ready,
  input  wire byte_t     pay_data,
  output logic           pay_pop,
  output beat_t          hdr,
  output logic           hdr_valid,
  input  wire            hdr_ready,
  output mac_addr_t      frame_dest_mac
);

  localparam int unsigned HDR_BYTES   = 28;        // ipv4 20 plus udp 8
  localparam csum_t       IP_VER_TOS  = 16'h4500;  // v4, ihl 5, tos 0
  localparam csum_t       IP_FLAGS    = 16'h4000;  // don't fragment
  localparam byte_t       IP_PROTO    = 8'd17;     // udp

  hdr_state_t   state;
  desc_t        cur_desc;
  ip_id_t       ip_id;
  csum_t        sum;
  csum_t        sum_word;
  logic [16:0]  sum_add;
  logic [3:0]   word_idx;
  logic [4:0]   byte_idx;
  len_t         pay_left;
  len_t         ip_len;
  len_t         udp_len;
  logic [8*HDR_BYTES-1:0] hdr_bytes;

  assign ip_len  = cur_desc.len + len_t'(28);
  assign udp_len = cur_desc.len + len_t'(8);

  // ----------------------------------------
  // checksum words, one per SUM cycle
  // ----------------------------------------
  always_comb begin
    case (word_idx)
      4'd0:    sum_word = IP_VER_TOS;
      4'd1:    sum_word = ip_len;
      4'd2:    sum_word = ip_id;
      4'd3:    sum_word = IP_FLAGS;
      4'd4:    sum_word = {`NET_IP_TTL, IP_PROTO};
      4'd5:    sum_word = '0;                   // checksum field itself
      4'd6:    sum_word = local_ip[31:16];
      4'd7:    sum_word = local_ip[15:0];
      4'd8:    sum_word = cur_desc.dest.ip[31:16];
      4'd9:    sum_word = cur_desc.dest.ip[15:0];
      default: sum_word = '0;
    endcase
  end

  assign sum_add = {1'b0, sum} + {1'b0, sum_word};

  // whole header, msb first
  assign hdr_bytes = {IP_VER_TOS, ip_len, ip_id, IP_FLAGS, `NET_IP_TTL, IP_PROTO, ~sum,
                      local_ip, cur_desc.dest.ip,
                      `NET_LOCAL_PORT, cur_desc.dest.port, udp_len, 16'h0000};

  always_comb begin
    if (state == HG_PAYLOAD) begin
      hdr.data = pay_data;
      hdr.last = pay_left == len_t'(1);
    end else begin
      hdr.data = hdr_bytes[8*(HDR_BYTES-1-byte_idx) +: 8];
      hdr.last = 1'b0;
    end
  end

  assign desc_ready     = state == HG_IDLE;
  assign hdr_valid      = (state == HG_HEADER) || (state == HG_PAYLOAD);
  assign pay_pop        = (state == HG_PAYLOAD) && hdr_ready;   // byte leaves with its beat
  assign frame_dest_mac = cur_desc.dest.mac;

  always_ff @(posedge tx_clock) begin
    if (state == HG_IDLE && desc_valid) begin
      cur_desc <= desc;
    end
  end

  // ----------------------------------------
  // fsm
  // ----------------------------------------
  always_ff @(posedge tx_clock) begin
    if (!rst_n) begin
      state    <= HG_IDLE;
      ip_id    <= '0;
      sum      <= '0;
      word_idx <= '0;
      byte_idx <= '0;
      pay_left <= '0;
    end else begin
      case (state)
        HG_IDLE: if (desc_valid) begin
          state    <= HG_SUM;
          sum      <= '0;
          word_idx <= '0;
        end
        HG_SUM: begin
          sum      <= sum_add[15:0] + csum_t'(sum_add[16]);   // end-around carry
          word_idx <= word_idx + 1'b1;
          if (word_idx == 4'd9) begin
            state    <= HG_HEADER;
            byte_idx <= '0;
          end
        end
        HG_HEADER: if (hdr_ready) begin
          byte_idx <= byte_idx + 1'b1;
          if (byte_idx == HDR_BYTES - 1) begin
            state    <= HG_PAYLOAD;
            pay_left <= cur_desc.len;
          end
        end
        HG_PAYLOAD: if (hdr_ready) begin
          pay_left <= pay_left - len_t'(1);
          if (hdr.last) begin
            state <= HG_IDLE;
            ip_id <= ip_id + 1'b1;   // next frame's identification
          end
        end
        default: state <= HG_IDLE;
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== rtl/eth_frame_tx.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "net_tx_params.svh"

module eth_frame_tx
  import net_frame_pkg::*;
  import net_ctrl_pkg::*;
(
  input  wire            tx_clock,
  input  wire            rst_n,
  input  wire mac_addr_t local_mac,
  input  wire beat_t     hdr,
  input  wire            hdr_valid,
  output logic           hdr_ready,
  input  wire mac_addr_t frame_dest_mac,
  output byte_t          phy_tx_data,
  output logic           phy_tx_valid
);

  localparam crc_t        CRC_POLY    = 32'hEDB8_8320;   // reflected 802.3
  localparam byte_t       PRE_BYTE    = 8'h55;
  localparam byte_t       SFD_BYTE    = 8'hD5;
  localparam logic [15:0] ETH_TYPE_IP = 16'h0800;

  frame_state_t  state;
  len_t          cnt;        // byte index in current section
  len_t          data_cnt;   // data bytes so far, pad included
  beat_t         beat_q;     // beat on the wire this cycle
  crc_t          crc;
  byte_t         tx_byte;
  logic          tx_on;
  logic          crc_en;
  logic [111:0]  mac_hdr;

  // one byte through the reflected crc, lsb first
  function automatic crc_t crc_next(crc_t c, byte_t d);
    crc_t r;
    r = c ^ {24'h0, d};
    for (int i = 0; i < 8; i++) begin
      r = r[0] ? ((r >> 1) ^ CRC_POLY) : (r >> 1);
    end
    return r;
  endfunction

  assign mac_hdr = {frame_dest_mac, local_mac, ETH_TYPE_IP};

  // ----------------------------------------
  // byte select
  // ----------------------------------------
  always_comb begin
    tx_byte = '0;
    tx_on   = 1'b1;
    case (state)
      FR_PREAMBLE: tx_byte = PRE_BYTE;
      FR_SFD:      tx_byte = SFD_BYTE;
      FR_MAC_HDR:  tx_byte = mac_hdr[8*(13-cnt[3:0]) +: 8];
      FR_DATA:     tx_byte = beat_q.data;
      FR_PAD:      tx_byte = '0;
      FR_FCS:      tx_byte = ~crc[8*cnt[1:0] +: 8];   // complemented, low byte first
      default:     tx_on   = 1'b0;                    // idle or gap
    endcase
  end

  // first beat is taken in the last mac header cycle
  assign hdr_ready = ((state == FR_MAC_HDR) && (cnt == len_t'(13))) ||
                     ((state == FR_DATA) && !beat_q.last);
  assign crc_en    = (state == FR_MAC_HDR) || (state == FR_DATA) || (state == FR_PAD);

  // phy outputs and beat register
  always_ff @(posedge tx_clock) begin
    phy_tx_data <= tx_byte;
    if (hdr_valid && hdr_ready) begin
      beat_q <= hdr;
    end
  end

  // ----------------------------------------
  // fsm
  // ----------------------------------------
  always_ff @(posedge tx_clock) begin
    if (!rst_n) begin
      state        <= FR_IDLE;
      cnt          <= '0;
      data_cnt     <= '0;
      crc          <= '1;
      phy_tx_valid <= 1'b0;
    end else begin
      phy_tx_valid <= tx_on;
      if (crc_en) begin
        crc <= crc_next(crc, tx_byte);
      end
      case (state)
        FR_IDLE: if (hdr_valid) begin   // header stream ready
          state <= FR_PREAMBLE;
          cnt   <= '0;
        end
        FR_PREAMBLE: begin
          if (cnt == `NET_PREAMBLE_LEN - 1) begin
            state <= FR_SFD;
          end else begin
            cnt <= cnt + len_t'(1);
          end
        end
        FR_SFD: begin
          state <= FR_MAC_HDR;
          cnt   <= '0;
          crc   <= '1;                  // crc starts at the dest mac
        end
        FR_MAC_HDR: begin
          if (cnt == len_t'(13)) begin
            state    <= FR_DATA;
            data_cnt <= '0;
          end else begin
            cnt <= cnt + len_t'(1);
          end
        end
        FR_DATA: begin
          data_cnt <= data_cnt + len_t'(1);
          if (beat_q.last) begin
            cnt   <= '0;
            state <= (data_cnt < `NET_MIN_DATA - 1) ? FR_PAD : FR_FCS;
          end
        end
        FR_PAD: begin
          data_cnt <= data_cnt + len_t'(1);
          if (data_cnt == `NET_MIN_DATA - 1) begin
            state <= FR_FCS;
          end
        end
        FR_FCS: begin
          cnt <= cnt + len_t'(1);
          if (cnt == len_t'(3)) begin
            state <= FR_GAP;
            cnt   <= '0;
          end
        end
        FR_GAP: begin   // idle one cycle more in FR_IDLE
          cnt <= cnt + len_t'(1);
          if (cnt == `NET_IFG_CYCLES - 1) begin
            state <= FR_IDLE;
          end
        end
        default: state <= FR_IDLE;
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== rtl/net_udp_tx.sv ====
`timescale 1ns/1ps
`default_nettype none

module net_udp_tx
  import net_frame_pkg::*;
  import net_ctrl_pkg::*;
(
  input  wire            tx_clock,
  input  wire            rst_n,
  // user payload
  input  wire byte_t     udp_tx_data,
  input  wire            udp_tx_valid,
  output wire            udp_tx_ready,
  input  wire len_t      udp_tx_length,
  // destination, held while run is high
  input  wire            run,
  input  wire mac_addr_t dest_mac,
  input  wire ip_addr_t  dest_ip,
  input  wire udp_port_t dest_port,
  // own addresses
  input  wire mac_addr_t local_mac,
  input  wire ip_addr_t  local_ip,
  // phy
  output wire byte_t     phy_tx_data,
  output wire            phy_tx_valid
);

  // ----------------------------------------
  // stage links
  // ----------------------------------------
  wire desc_t     desc;
  wire            desc_valid;
  wire            desc_ready;
  wire byte_t     pay_data;
  wire            pay_pop;
  wire beat_t     hdr;
  wire            hdr_valid;
  wire            hdr_ready;
  wire mac_addr_t frame_dest_mac;

  udp_tx_intake u_intake (
    .tx_clock      (tx_clock),
    .rst_n         (rst_n),
    .udp_tx_data   (udp_tx_data),
    .udp_tx_valid  (udp_tx_valid),
    .udp_tx_ready  (udp_tx_ready),
    .udp_tx_length (udp_tx_length),
    .run           (run),
    .dest_mac      (dest_mac),
    .dest_ip       (dest_ip),
    .dest_port     (dest_port),
    .desc          (desc),
    .desc_valid    (desc_valid),
    .desc_ready    (desc_ready),
    .pay_data      (pay_data),
    .pay_pop       (pay_pop)
  );

  ip_udp_header_gen u_hdr_gen (
    .tx_clock       (tx_clock),
    .rst_n          (rst_n),
    .local_ip       (local_ip),
    .desc           (desc),
    .desc_valid     (desc_valid),
    .desc_ready     (desc_ready),
    .pay_data       (pay_data),
    .pay_pop        (pay_pop),
    .hdr            (hdr),
    .hdr_valid      (hdr_valid),
    .hdr_ready      (hdr_ready),
    .frame_dest_mac (frame_dest_mac)
  );

  eth_frame_tx u_framer (
    .tx_clock       (tx_clock),
    .rst_n          (rst_n),
    .local_mac      (local_mac),
    .hdr            (hdr),
    .hdr_valid      (hdr_valid),
    .hdr_ready      (hdr_ready),
    .frame_dest_mac (frame_dest_mac),
    .phy_tx_data    (phy_tx_data),
    .phy_tx_valid   (phy_tx_valid)
  );

endmodule

`default_nettype wire

// ==== verification/net_udp_tx_props.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "net_tx_params.svh"

module net_udp_tx_props
  import net_ctrl_pkg::*;
#(
  parameter bit FRAMER_SIDE = 1'b1   // framer checks, else intake checks
) (
  input wire                             tx_clock,
  input wire                             rst_n,
  input wire frame_state_t               state,
  input wire                             beat_last,
  input wire                             hdr_valid,
  input wire                             phy_tx_valid,
  input wire                             udp_tx_ready,
  input wire [$clog2(`NET_FIFO_DEPTH):0] buf_fill,
  input wire [$clog2(`NET_DESC_DEPTH):0] desc_fill
);

  if (FRAMER_SIDE) begin : g_framer
    // framer pulls one beat per cycle until the last one
    a_hdr_valid_in_data: assert property (@(posedge tx_clock) disable iff (!rst_n)
      (state == FR_DATA && !beat_last) |-> hdr_valid)
      else $error("hdr_valid low in the data section before last");
    // valid drops only once the last fcs byte is out
    a_phy_valid_unbroken: assert property (@(posedge tx_clock) disable iff (!rst_n)
      $fell(phy_tx_valid) |-> ($past(state, 2) == FR_FCS))
      else $error("phy_tx_valid dropped inside a frame");
  end else begin : g_intake
    // fill stays within depth on both queues
    a_fill_in_range: assert property (@(posedge tx_clock) disable iff (!rst_n)
      (buf_fill <= `NET_FIFO_DEPTH) && (desc_fill <= `NET_DESC_DEPTH))
      else $error("payload buffer or descriptor queue fill out of range");
    a_ready_with_room: assert property (@(posedge tx_clock) disable iff (!rst_n)
      (buf_fill != `NET_FIFO_DEPTH && desc_fill != `NET_DESC_DEPTH) |-> udp_tx_ready)
      else $error("udp_tx_ready low although buffer and queue have room");
  end

endmodule

// ----------------------------------------
// attach to framer and intake
// ----------------------------------------
bind eth_frame_tx net_udp_tx_props #(.FRAMER_SIDE(1'b1)) u_framer_props (
  .tx_clock     (tx_clock),
  .rst_n        (rst_n),
  .state        (state),
  .beat_last    (beat_q.last),
  .hdr_valid    (hdr_valid),
  .phy_tx_valid (phy_tx_valid),
  .udp_tx_ready (1'b1),
  .buf_fill     ('0),
  .desc_fill    ('0)
);

bind udp_tx_intake net_udp_tx_props #(.FRAMER_SIDE(1'b0)) u_intake_props (
  .tx_clock     (tx_clock),
  .rst_n        (rst_n),
  .state        (FR_IDLE),
  .beat_last    (1'b0),
  .hdr_valid    (1'b0),
  .phy_tx_valid (1'b0),
  .udp_tx_ready (udp_tx_ready),
  .buf_fill     (buf_fill),
  .desc_fill    (desc_fill)
);

`default_nettype wire

// ==== verification/net_udp_tx_tb.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "net_tx_params.svh"

module net_udp_tx_tb
  import net_frame_pkg::*;
  import net_ctrl_pkg::*;
;

  localparam int        N_RANDOM  = 12;
  localparam int        N_PKTS    = 4 + 1 + N_RANDOM + 2;    // all sections together
  localparam int        WD_CYCLES = N_PKTS * (1600 + `NET_IFG_CYCLES) + N_PKTS * 200 + 1000;
  localparam mac_addr_t LOCAL_MAC = 48'h02_00_5e_10_20_30;
  localparam ip_addr_t  LOCAL_IP  = 32'hc0a8_0a02;
  localparam dest_t     DEST0     = {48'h0a_1b_2c_3d_4e_5f, 32'hc0a8_0a64, 16'd5000};
  localparam dest_t     DEST_A    = {48'h0a_00_00_00_00_aa, 32'h0a00_00aa, 16'd7001};
  localparam dest_t     DEST_B    = {48'h0a_00_00_00_00_bb, 32'h0a00_00bb, 16'd7002};

  logic      tx_clock;
  logic      rst_n;
  byte_t     udp_tx_data;
  logic      udp_tx_valid;
  logic      udp_tx_ready;
  len_t      udp_tx_length;
  logic      run;
  mac_addr_t dest_mac;
  ip_addr_t  dest_ip;
  udp_port_t dest_port;
  byte_t     phy_tx_data;
  logic      phy_tx_valid;

  byte_t  pay_buf [`NET_MAX_PAYLOAD];   // payload of the packet being sent
  byte_t  exp_bytes [$];                // expected wire bytes, all frames
  len_t   exp_lens [$];                 // expected frame lengths
  ip_id_t next_id = '0;
  int     err_value = 0;
  int     err_frame = 0;
  logic   in_frame = 1'b0;
  len_t   byte_idx = '0;
  len_t   cur_exp_len = '0;
  len_t   gap_cnt = '0;
  int     frames_seen = 0;

  net_udp_tx u_net_udp_tx (
    .tx_clock      (tx_clock),
    .rst_n         (rst_n),
    .udp_tx_data   (udp_tx_data),
    .udp_tx_valid  (udp_tx_valid),
    .udp_tx_ready  (udp_tx_ready),
    .udp_tx_length (udp_tx_length),
    .run           (run),
    .dest_mac      (dest_mac),
    .dest_ip       (dest_ip),
    .dest_port     (dest_port),
    .local_mac     (LOCAL_MAC),
    .local_ip      (LOCAL_IP),
    .phy_tx_data   (phy_tx_data),
    .phy_tx_valid  (phy_tx_valid)
  );

  initial begin
    tx_clock = 1'b0;
    forever #10 tx_clock = ~tx_clock;   // 50 MHz
  end

  // ----------------------------------------
  // compare tasks
  // ----------------------------------------
  task automatic check_byte(string name, byte_t act, byte_t exp);
    if (act !== exp) begin
      err_value++;
      $display("[FAIL] t=%0t %s: got %02h, expected %02h", $time, name, act, exp);
    end
  endtask

  task automatic check_len(string name, len_t act, len_t exp, bit at_least);
    if (at_least ? (act < exp) : (act !== exp)) begin
      err_value++;
      $display("[FAIL] t=%0t %s: got %0d, expected %s%0d", $time, name, act,
               at_least ? "at least " : "", exp);
    end
  endtask

  task automatic check_bit(string name, logic act, logic exp);
    if (act !== exp) begin
      err_value++;
      $display("[FAIL] t=%0t %s: got %b, expected %b", $time, name, act, exp);
    end
  endtask

  // ----------------------------------------
  // reference frame, pushed onto exp_bytes
  // ----------------------------------------
  function automatic len_t build_frame(len_t len, dest_t dst, ip_id_t id);
    byte_t        body [1520];   // dest mac through pad
    logic [335:0] hdr_bits;      // mac, ipv4 and udp headers
    logic [31:0]  acc;
    csum_t        csum;
    crc_t         crc;
    int           data_len;
    int           n;
    data_len = (int'(len) + 28 > `NET_MIN_DATA) ? int'(len) + 28 : `NET_MIN_DATA;
    acc = 32'h4500 + 32'(len + 16'd28) + 32'(id) + 32'h4000 + 32'({`NET_IP_TTL, 8'd17})
        + 32'(LOCAL_IP[31:16]) + 32'(LOCAL_IP[15:0]) + 32'(dst.ip[31:16]) + 32'(dst.ip[15:0]);
    acc  = acc[15:0] + acc[31:16];   // fold carries twice
    acc  = acc[15:0] + acc[31:16];
    csum = ~acc[15:0];
    hdr_bits = {dst.mac, LOCAL_MAC, 16'h0800,
                16'h4500, len + 16'd28, id, 16'h4000, `NET_IP_TTL, 8'd17, csum,
                LOCAL_IP, dst.ip,
                `NET_LOCAL_PORT, dst.port, len + 16'd8, 16'h0000};
    for (n = 0; n < 42; n++) begin
      body[n] = hdr_bits[335-8*n -: 8];
    end
    for (n = 0; n < 14 + data_len; n++) begin
      if (n >= 42) begin
        body[n] = (n - 42 < int'(len)) ? pay_buf[n-42] : 8'h00;   // payload, then pad
      end
    end
    crc = '1;
    for (int i = 0; i < n; i++) begin
      crc = crc ^ {24'h0, body[i]};
      for (int b = 0; b < 8; b++) begin
        crc = crc[0] ? ((crc >> 1) ^ 32'hEDB8_8320) : (crc >> 1);
      end
    end
    crc = ~crc;
    for (int i = 0; i < `NET_PREAMBLE_LEN; i++) begin
      exp_bytes.push_back(8'h55);
    end
    exp_bytes.push_back(8'hD5);
    for (int i = 0; i < n; i++) begin
      exp_bytes.push_back(body[i]);
    end
    for (int i = 0; i < 4; i++) begin
      exp_bytes.push_back(crc[8*i +: 8]);   // fcs low byte first
    end
    return len_t'(8 + n + 4);
  endfunction

  // ----------------------------------------
  // stimulus helpers, called at a falling edge
  // ----------------------------------------
  task automatic set_dest(dest_t d);
    dest_mac  = d.mac;
    dest_ip   = d.ip;
    dest_port = d.port;
  endtask

  task automatic send_payload(len_t len, bit gaps);
    int   i;
    logic xfer;
    i = 0;
    udp_tx_length = len;
    while (i < int'(len)) begin
      udp_tx_valid = !(gaps && ($urandom % 8 == 0));   // occasional idle cycle
      udp_tx_data  = pay_buf[i];
      xfer = udp_tx_valid && udp_tx_ready;             // ready stable until next rise
      @(negedge tx_clock);
      if (xfer) begin
        i++;
      end
    end
    udp_tx_valid = 1'b0;
  endtask

  task automatic queue_packet(len_t len, dest_t dst, bit gaps);
    int i;
    for (i = 0; i < int'(len); i++) begin
      pay_buf[i] = byte_t'($urandom);
    end
    exp_lens.push_back(build_frame(len, dst, next_id));
    next_id++;
    send_payload(len, gaps);
  endtask

  // ----------------------------------------
  // monitor and compare
  // ----------------------------------------
  always @(negedge tx_clock) begin
    if (rst_n) begin
      if (phy_tx_valid) begin
        if (!in_frame) begin   // frame start
          in_frame = 1'b1;
          byte_idx = '0;
          if (frames_seen > 0) begin
            check_len("phy_tx_valid idle gap", gap_cnt, `NET_IFG_CYCLES, 1'b1);
          end
          if (exp_lens.size() == 0) begin
            err_frame++;
            $display("t=%0t an extra frame appeared with no packet sent for it", $time);
            cur_exp_len = '0;
          end else begin
            cur_exp_len = exp_lens.pop_front();
          end
        end
        if (byte_idx < cur_exp_len) begin
          check_byte($sformatf("phy_tx_data[%0d]", byte_idx), phy_tx_data,
                     exp_bytes.pop_front());
        end
        byte_idx++;
      end else if (in_frame) begin   // first idle cycle after a frame
        in_frame = 1'b0;
        frames_seen++;
        gap_cnt = len_t'(1);
        if (cur_exp_len != 0) begin
          check_len("frame length", byte_idx, cur_exp_len, 1'b0);
        end
        while (byte_idx < cur_exp_len) begin   // drop what a short frame missed
          exp_bytes.delete(0);
          byte_idx++;
        end
      end else if (gap_cnt != '1) begin
        gap_cnt++;
      end
    end
  end

  initial begin : watchdog
    repeat (WD_CYCLES) @(posedge tx_clock);
    $display("timeout after %0d cycles, %0d frames never appeared", WD_CYCLES, exp_lens.size());
    $display("errors: %0d value mismatches, %0d frame errors", err_value, err_frame + 1);
    $display("STATUS: FAIL");
    $finish;
  end

  // ----------------------------------------
  // main sequence
  // ----------------------------------------
  initial begin : stimulus
    int seed_init;
    rst_n         = 1'b0;
    udp_tx_data   = '0;
    udp_tx_valid  = 1'b0;
    udp_tx_length = '0;
    run           = 1'b0;
    set_dest(DEST0);
    seed_init = $urandom(32'h28fc_d061);
    repeat (10) @(negedge tx_clock);
    rst_n = 1'b1;
    // idle after reset
    repeat (20) begin
      @(negedge tx_clock);
      check_bit("phy_tx_valid", phy_tx_valid, 1'b0);
      check_bit("udp_tx_ready", udp_tx_ready, 1'b1);
    end
    // four back to back, ids 0..3
    queue_packet(16'd20, DEST0, 1'b0);
    queue_packet(16'd64, DEST0, 1'b0);
    queue_packet(16'd150, DEST0, 1'b0);
    queue_packet(16'd7, DEST0, 1'b0);
    queue_packet(16'd10, DEST0, 1'b0);   // short one, padded to 46
    repeat (N_RANDOM) begin
      queue_packet(len_t'(1 + $urandom % `NET_MAX_PAYLOAD), DEST0, 1'b1);
    end
    // held destination
    set_dest(DEST_A);
    repeat (2) @(negedge tx_clock);
    run = 1'b1;
    set_dest(DEST_B);   // ignored while run is high
    repeat (2) @(negedge tx_clock);
    queue_packet(16'd33, DEST_A, 1'b0);
    run = 1'b0;
    repeat (2) @(negedge tx_clock);
    queue_packet(16'd80, DEST_B, 1'b0);
    while (exp_lens.size() != 0 || in_frame) begin
      @(negedge tx_clock);
    end
    repeat (50) @(negedge tx_clock);   // catch trailing extra frames
    $display("errors: %0d value mismatches, %0d frame errors", err_value, err_frame);
    if (err_value + err_frame == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== net_udp_tx.f ====
+incdir+rtl
rtl/net_frame_pkg.sv
rtl/net_ctrl_pkg.sv
rtl/udp_tx_intake.sv
rtl/ip_udp_header_gen.sv
rtl/eth_frame_tx.sv
rtl/net_udp_tx.sv
verification/net_udp_tx_props.sv
verification/net_udp_tx_tb.sv
